// ==== cacheTop.f ====
+incdir+common
common/cachePkg.sv
logic/cacheArray.sv
cacheWay/cacheWay.sv
logic/wayMerge.sv
cacheCtrl/cacheCtrl.sv
logic/cacheTop.sv
dv/cacheTop_assertions.sv
dv/cacheChecker.sv
dv/cacheTop_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = cacheTop_tb
FILELIST = cacheTop.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

lint:
	$(SIM) --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/cacheTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTop_tb;

  localparam int NumReq      = 400;
  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 16;
  // ready wait, four beats with gaps, write, replay and lookup, with margin
  localparam int MissCycles  = 48;
  localparam int WatchdogNs  = (ResetCycles + NumReq * MissCycles) * ClkPeriod;

  logic               clk;
  logic               rst_n;
  logic               reqValid;
  logic [`ADDR_W-1:0] reqAddr;
  logic               addrOk;
  logic               dataOk;
  logic [`XLEN-1:0]   rdData;
  logic               memRdValid;
  logic [`ADDR_W-1:0] memAddr;
  logic               memRdReady;
  logic               memBeatValid;
  logic [`XLEN-1:0]   memBeatData;
  logic               memRdLast;

  logic [31:0]        lfsrState;
  logic               willTake;
  logic               willGrant;
  logic               inBurst;
  logic [`ADDR_W-1:0] grantAddr;
  logic [`ADDR_W-1:0] burstAddr;
  int                 beatNum;
  int                 sent;
  int                 errors;
  int                 results;
  int                 pending;
  int                 assertFails;

  cacheTop dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (reqValid),
    .reqAddr_i      (reqAddr),
    .addrOk_o       (addrOk),
    .dataOk_o       (dataOk),
    .rdData_o       (rdData),
    .memRdValid_o   (memRdValid),
    .memAddr_o      (memAddr),
    .memRdReady_i   (memRdReady),
    .memBeatValid_i (memBeatValid),
    .memBeatData_i  (memBeatData),
    .memRdLast_i    (memRdLast)
  );

  cacheChecker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid),
    .reqAddr_i    (reqAddr),
    .addrOk_i     (addrOk),
    .dataOk_i     (dataOk),
    .rdData_i     (rdData),
    .memRdValid_i (memRdValid),
    .memRdReady_i (memRdReady),
    .memAddr_i    (memAddr),
    .errors_o     (errors),
    .results_o    (results),
    .pending_o    (pending)
  );

  bind cacheCtrl cacheTop_assertions asrt0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_i     (lookup_o),
    .hit_i        (hit_i),
    .addrOk_i     (addrOk_o),
    .dataOk_i     (dataOk_o),
    .memRdValid_i (memRdValid_o),
    .memRdReady_i (memRdReady_i),
    .memAddr_i    (memAddr_o),
    .refill_i     (refill_o)
  );

  assign assertFails = dut0.ctrl0.asrt0.failCount;

  always #(ClkPeriod / 2) clk = ~clk;

  // fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      val = {val[30:0], lfsrState[0]};
    end
  endtask

  function automatic logic [`XLEN-1:0] wordAt(input logic [`ADDR_W-1:0] a);
    return {~a, a};
  endfunction

  // four sets, three tags each, so sets overflow and evict
  function automatic logic [`ADDR_W-1:0] makeAddr(input logic [1:0] setSel,
                                                  input logic [1:0] tagSel,
                                                  input logic [1:0] word);
    return {tagSel, 19'h2a5c3, setSel, 4'h9, word, 3'b000};
  endfunction

  task automatic driveRequest();
    logic [31:0] r;
    logic [1:0]  setSel;
    logic [1:0]  tagSel;
    logic [1:0]  word;
    // addrOk cannot change before the next rising edge
    if (!reqValid || willTake) begin
      takeBits(2, r);
      if (r[1:0] != 2'b00 && sent < NumReq) begin
        takeBits(2, r);
        setSel = r[1:0];
        takeBits(2, r);
        tagSel = (r[1:0] == 2'b11) ? 2'b00 : r[1:0];
        takeBits(2, r);
        word = r[1:0];
        reqValid = 1'b1;
        reqAddr  = makeAddr(setSel, tagSel, word);
        sent++;
      end else begin
        reqValid = 1'b0;
      end
    end
    willTake = reqValid && addrOk;
  endtask

  task automatic driveMemory();
    logic [31:0] r;
    if (willGrant) begin
      inBurst   = 1'b1;
      beatNum   = 0;
      burstAddr = grantAddr;
    end
    memRdReady   = 1'b0;
    memBeatValid = 1'b0;
    memRdLast    = 1'b0;
    if (inBurst) begin
      // one cycle in four left empty
      takeBits(2, r);
      if (r[1:0] != 2'b00) begin
        memBeatValid = 1'b1;
        memBeatData  = wordAt(burstAddr + 32'(beatNum * 8));
        memRdLast    = (beatNum == `CACHE_WORDS - 1);
        beatNum++;
        if (beatNum == `CACHE_WORDS) begin
          inBurst = 1'b0;
        end
      end
    end else if (memRdValid) begin
      takeBits(1, r);
      memRdReady = r[0];
    end
    willGrant = memRdValid && memRdReady;
    grantAddr = memAddr;
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    reqValid     = 1'b0;
    reqAddr      = '0;
    memRdReady   = 1'b0;
    memBeatValid = 1'b0;
    memBeatData  = '0;
    memRdLast    = 1'b0;
    lfsrState    = 32'h5620e21f;
    willTake     = 1'b0;
    willGrant    = 1'b0;
    inBurst      = 1'b0;
    grantAddr    = '0;
    burstAddr    = '0;
    beatNum      = 0;
    sent         = 0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (results < NumReq) begin
      @(negedge clk);
      driveRequest();
      driveMemory();
    end
    reqValid = 1'b0;
    repeat (4) @(posedge clk);
    $display("errors: %0d checker, %0d assertion, %0d unfinished",
             errors, assertFails, pending);
    if (errors == 0 && assertFails == 0 && pending == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout: only %0d of %0d results after %0d ns", results, NumReq, WatchdogNs);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/cacheChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

// scoreboard with a two-way LRU reference of the cache
module cacheChecker (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               reqValid_i,
  input  wire logic [`ADDR_W-1:0] reqAddr_i,
  input  wire logic               addrOk_i,
  input  wire logic               dataOk_i,
  input  wire logic [`XLEN-1:0]   rdData_i,
  input  wire logic               memRdValid_i,
  input  wire logic               memRdReady_i,
  input  wire logic [`ADDR_W-1:0] memAddr_i,
  output int                      errors_o,
  output int                      results_o,
  output int                      pending_o
);

  localparam int OffsW = `ADDR_W - `TAG_W - `IDX_W;

  logic [1:0]             validM [`CACHE_SETS];
  logic [1:0][`TAG_W-1:0] tagM [`CACHE_SETS];
  logic                   lruM [`CACHE_SETS];
  logic [`ADDR_W-1:0]     addrQ [$];
  logic [`ADDR_W-1:0]     memQ [$];
  bit                     hitQ [$];
  int                     cycQ [$];
  int                     cyc = 0;
  int                     errCount = 0;
  int                     resCount = 0;
  int                     pendCount = 0;

  assign errors_o  = errCount;
  assign results_o = resCount;
  assign pending_o = pendCount;

  // memory content: inverted address above the address
  function automatic logic [`XLEN-1:0] memWord(input logic [`ADDR_W-1:0] a);
    return {~a, a};
  endfunction

  always @(posedge clk) begin
    logic [`ADDR_W-1:0] a;
    logic [`ADDR_W-1:0] expAddr;
    logic [`XLEN-1:0]   expData;
    logic [`TAG_W-1:0]  t;
    logic [`IDX_W-1:0]  ix;
    logic               w;
    bit                 h;
    int                 c;
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        validM[s] = 2'b00;
        lruM[s]   = 1'b0;
      end
      if (addrOk_i !== 1'b1 || dataOk_i !== 1'b0 || memRdValid_i !== 1'b0) begin
        errCount++;
        $display("CHECK FAILED reset: addrOk_o %h dataOk_o %h memRdValid_o %h, expected 1 0 0",
                 addrOk_i, dataOk_i, memRdValid_i);
      end
    end else begin
      cyc++;
      if (dataOk_i) begin
        if (addrQ.size() == 0) begin
          errCount++;
          $display("result returned with no request outstanding");
        end else begin
          a = addrQ.pop_front();
          h = hitQ.pop_front();
          c = cycQ.pop_front();
          resCount++;
          expData = memWord({a[`ADDR_W-1:3], 3'b000});
          if (rdData_i !== expData) begin
            errCount++;
            $display("CHECK FAILED rdData_o: got %h, expected %h for address %h",
                     rdData_i, expData, a);
          end
          if (h && cyc != c + 1) begin
            errCount++;
            $display("hit on address %h took %0d cycles instead of one", a, cyc - c);
          end
          if (!h && memQ.size() != 0) begin
            errCount++;
            $display("miss on address %h returned before its line was requested", a);
          end
        end
      end
      if (memRdValid_i && memRdReady_i) begin
        if (memQ.size() == 0) begin
          errCount++;
          $display("memory request for %h made without a predicted miss", memAddr_i);
        end else begin
          expAddr = memQ.pop_front();
          if (memAddr_i !== expAddr) begin
            errCount++;
            $display("CHECK FAILED memAddr_o: got %h, expected %h", memAddr_i, expAddr);
          end
        end
      end
      if (reqValid_i && addrOk_i) begin
        a  = reqAddr_i;
        t  = a[`ADDR_W-1:`ADDR_W-`TAG_W];
        ix = a[`ADDR_W-`TAG_W-1:OffsW];
        h  = 1'b1;
        if (validM[ix][0] && tagM[ix][0] == t) begin
          w = 1'b0;
        end else if (validM[ix][1] && tagM[ix][1] == t) begin
          w = 1'b1;
        end else begin
          h = 1'b0;
          // empty way first, then the older one
          if (!validM[ix][0]) begin
            w = 1'b0;
          end else if (!validM[ix][1]) begin
            w = 1'b1;
          end else begin
            w = lruM[ix];
          end
          validM[ix][w] = 1'b1;
          tagM[ix][w]   = t;
          memQ.push_back({a[`ADDR_W-1:OffsW], {OffsW{1'b0}}});
        end
        lruM[ix] = ~w;
        addrQ.push_back(a);
        hitQ.push_back(h);
        cycQ.push_back(cyc);
      end
      pendCount = addrQ.size() + memQ.size();
    end
  end

endmodule

`default_nettype wire

// ==== dv/cacheTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

// protocol checks on the cache controller
module cacheTop_assertions (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               lookup_i,
  input wire logic               hit_i,
  input wire logic               addrOk_i,
  input wire logic               dataOk_i,
  input wire logic               memRdValid_i,
  input wire logic               memRdReady_i,
  input wire logic [`ADDR_W-1:0] memAddr_i,
  input wire cachePkg::refillT   refill_i
);

  int failCount = 0;

  // line request stays up with a steady address until taken
  holdReq: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i && !memRdReady_i |=> memRdValid_i && $stable(memAddr_i))
    else begin
      failCount++;
      $error("memRdValid_o dropped or memAddr_o changed before memRdReady_i");
    end

  // written line is replayed and hits two cycles later
  replayHits: assert property (@(posedge clk) disable iff (!rst_n)
    refill_i.we |-> ##2 dataOk_i)
    else begin
      failCount++;
      $error("replayed lookup after a refill write returned no data");
    end

  // a missing lookup goes straight to the memory request
  missToMem: assert property (@(posedge clk) disable iff (!rst_n)
    lookup_i && !hit_i |=> memRdValid_i)
    else begin
      failCount++;
      $error("lookup missed but no memory request followed");
    end

  blockDuringMiss: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_i |-> !addrOk_i && !dataOk_i)
    else begin
      failCount++;
      $error("requester handshake active during a memory request");
    end

  // one write cycle per refill
  singleWrite: assert property (@(posedge clk) disable iff (!rst_n)
    refill_i.we |=> !refill_i.we)
    else begin
      failCount++;
      $error("refill write lasted more than one cycle");
    end

endmodule

`default_nettype wire

// ==== logic/cacheTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheTop (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               valid_i,
  input  wire logic [`ADDR_W-1:0] reqAddr_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic [`XLEN-1:0]        rdData_o,
  output logic                    memRdValid_o,
  output logic [`ADDR_W-1:0]      memAddr_o,
  input  wire logic               memRdReady_i,
  input  wire logic               memBeatValid_i,
  input  wire logic [`XLEN-1:0]   memBeatData_i,
  input  wire logic               memRdLast_i
);

  cachePkg::cacheReqT rdReq;
  cachePkg::cacheReqT lookReq;
  cachePkg::refillT   refill;
  cachePkg::wayRespT  resp0;
  cachePkg::wayRespT  resp1;
  logic               rdEn;
  logic               lookup;
  logic               hit;
  logic               victim;

  cacheCtrl ctrl0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .reqAddr_i      (reqAddr_i),
    .hit_i          (hit),
    .victim_i       (victim),
    .memRdReady_i   (memRdReady_i),
    .memBeatValid_i (memBeatValid_i),
    .memBeatData_i  (memBeatData_i),
    .memRdLast_i    (memRdLast_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .rdReq_o        (rdReq),
    .rdEn_o         (rdEn),
    .lookup_o       (lookup),
    .lookReq_o      (lookReq),
    .refill_o       (refill),
    .memRdValid_o   (memRdValid_o),
    .memAddr_o      (memAddr_o)
  );

  cacheWay way0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdReq_i  (rdReq),
    .rdEn_i   (rdEn),
    .refill_i (refill),
    .wayId_i  (1'b0),
    .resp_o   (resp0)
  );

  cacheWay way1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdReq_i  (rdReq),
    .rdEn_i   (rdEn),
    .refill_i (refill),
    .wayId_i  (1'b1),
    .resp_o   (resp1)
  );

  wayMerge merge0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .resp0_i    (resp0),
    .resp1_i    (resp1),
    .lookIdx_i  (lookReq.idx),
    .lookOffs_i (lookReq.offs),
    .lookup_i   (lookup),
    .refill_i   (refill),
    .hit_o      (hit),
    .victim_o   (victim),
    .rdData_o   (rdData_o)
  );

endmodule

`default_nettype wire

// ==== cacheCtrl/cacheCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheCtrl (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               valid_i,
  input  wire logic [`ADDR_W-1:0] reqAddr_i,
  input  wire logic               hit_i,
  input  wire logic               victim_i,
  input  wire logic               memRdReady_i,
  input  wire logic               memBeatValid_i,
  input  wire logic [`XLEN-1:0]   memBeatData_i,
  input  wire logic               memRdLast_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output cachePkg::cacheReqT      rdReq_o,
  output logic                    rdEn_o,
  output logic                    lookup_o,
  output cachePkg::cacheReqT      lookReq_o,
  output cachePkg::refillT        refill_o,
  output logic                    memRdValid_o,
  output logic [`ADDR_W-1:0]      memAddr_o
);

  typedef enum logic [2:0] {
    StIdle,
    StLookup,
    StMiss,
    StRefill,
    StReplay
  } stateT;

  stateT              stateQ;
  stateT              stateD;
  cachePkg::cacheReqT reqQ;
  cachePkg::lineT     lineQ;
  logic               victimQ;
  logic               fillDone;
  logic               accept;
  logic               beatTake;

  assign lookup_o = (stateQ == StLookup);
  assign dataOk_o = lookup_o && hit_i;

  // a hitting lookup frees the arrays for the next request
  assign addrOk_o = (stateQ == StIdle) || (lookup_o && hit_i);
  assign accept   = valid_i && addrOk_o;

  // new requests read straight from the port, replay uses the latch
  assign rdEn_o  = accept || (stateQ == StReplay);
  assign rdReq_o = (stateQ == StReplay) ? reqQ : cachePkg::cacheReqT'(reqAddr_i);

  assign lookReq_o = reqQ;

  assign memRdValid_o = (stateQ == StMiss);
  assign memAddr_o    = {reqQ.tag, reqQ.idx, {$bits(cachePkg::offsT){1'b0}}};

  assign beatTake = (stateQ == StRefill) && memBeatValid_i && !fillDone;

  // write cycle follows the last beat
  assign refill_o.we   = (stateQ == StRefill) && fillDone;
  assign refill_o.way  = victimQ;
  assign refill_o.idx  = reqQ.idx;
  assign refill_o.tag  = reqQ.tag;
  assign refill_o.line = lineQ;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      StIdle: begin
        if (valid_i) begin
          stateD = StLookup;
        end
      end
      StLookup: begin
        if (!hit_i) begin
          stateD = StMiss;
        end else if (!valid_i) begin
          stateD = StIdle;
        end
      end
      StMiss: begin
        if (memRdReady_i) begin
          stateD = StRefill;
        end
      end
      StRefill: begin
        if (fillDone) begin
          stateD = StReplay;
        end
      end
      StReplay: begin
        stateD = StLookup;
      end
      default: begin
        stateD = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ   <= StIdle;
      fillDone <= 1'b0;
    end else begin
      stateQ <= stateD;
      if (refill_o.we) begin
        fillDone <= 1'b0;
      end else if (beatTake && memRdLast_i) begin
        fillDone <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= cachePkg::cacheReqT'(reqAddr_i);
    end
    // victim held for the whole refill
    if (lookup_o && !hit_i) begin
      victimQ <= victim_i;
    end
    // beats arrive in word order, shift down from the top
    if (beatTake) begin
      lineQ <= {memBeatData_i, lineQ[`CACHE_WORDS-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== logic/wayMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module wayMerge (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire cachePkg::wayRespT resp0_i,
  input  wire cachePkg::wayRespT resp1_i,
  input  wire cachePkg::idxT     lookIdx_i,
  input  wire cachePkg::offsT    lookOffs_i,
  input  wire logic              lookup_i,
  input  wire cachePkg::refillT  refill_i,
  output logic                   hit_o,
  output logic                   victim_o,
  output logic [`XLEN-1:0]       rdData_o
);

  // set bit names the way to replace next
  logic [`CACHE_SETS-1:0] lruBits;
  cachePkg::lineT         hitLine;

  assign hit_o = resp0_i.hit || resp1_i.hit;

  // both ways never hold the same tag
  assign hitLine = resp0_i.hit ? resp0_i.line : resp1_i.line;

  // word select, offset bits 2:0 are the byte within the word
  assign rdData_o = hitLine[lookOffs_i[4:3]];

  // empty way first, way 0 before way 1
  always_comb begin
    if (!resp0_i.valid) begin
      victim_o = 1'b0;
    end else if (!resp1_i.valid) begin
      victim_o = 1'b1;
    end else begin
      victim_o = lruBits[lookIdx_i];
    end
  end

  // a touched way makes the other one least recent
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lruBits <= '0;
    end else if (refill_i.we) begin
      lruBits[refill_i.idx] <= ~refill_i.way;
    end else if (lookup_i && hit_o) begin
      lruBits[lookIdx_i] <= resp0_i.hit;
    end
  end

endmodule

`default_nettype wire

// ==== cacheWay/cacheWay.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheWay (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire cachePkg::cacheReqT rdReq_i,
  input  wire logic               rdEn_i,
  input  wire cachePkg::refillT   refill_i,
  input  wire logic               wayId_i,
  output cachePkg::wayRespT       resp_o
);

  logic                   wrEn;
  cachePkg::idxT          arrAddr;
  logic [`CACHE_SETS-1:0] validBits;
  logic                   validQ;
  cachePkg::tagT          tagQ;
  cachePkg::tagT          tagRd;
  cachePkg::lineT         lineRd;

  // only the victim way takes the refill
  assign wrEn = refill_i.we && (refill_i.way == wayId_i);

  // the controller never reads in a refill write cycle
  assign arrAddr = wrEn ? refill_i.idx : rdReq_i.idx;

  cacheArray #(
    .entryT(cachePkg::tagT)
  ) tagArr (
    .clk      (clk),
    .addr_i   (arrAddr),
    .we_i     (wrEn),
    .wrData_i (refill_i.tag),
    .rdData_o (tagRd)
  );

  cacheArray #(
    .entryT(cachePkg::lineT)
  ) dataArr (
    .clk      (clk),
    .addr_i   (arrAddr),
    .we_i     (wrEn),
    .wrData_i (refill_i.line),
    .rdData_o (lineRd)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (wrEn) begin
      validBits[refill_i.idx] <= 1'b1;
    end
  end

  // valid bit sampled alongside the array read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (rdEn_i) begin
      validQ <= validBits[rdReq_i.idx];
    end
  end

  // tag of the request now in lookup
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      tagQ <= rdReq_i.tag;
    end
  end

  assign resp_o.valid = validQ;
  assign resp_o.hit   = validQ && (tagRd == tagQ);
  assign resp_o.line  = lineRd;

endmodule

`default_nettype wire

// ==== logic/cacheArray.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

// behavioral single-port array with a registered read
module cacheArray #(
  parameter type entryT = logic
) (
  input  wire logic              clk,
  input  wire logic [`IDX_W-1:0] addr_i,
  input  wire logic              we_i,
  input  wire entryT             wrData_i,
  output entryT                  rdData_o
);

  entryT mem [`CACHE_SETS];

  // read-first, a write returns the old entry
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= wrData_i;
    end
    rdData_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none

`include "cache_macros.svh"

package cachePkg;

  typedef logic [`TAG_W-1:0] tagT;
  typedef logic [`IDX_W-1:0] idxT;
  typedef logic [`ADDR_W-`TAG_W-`IDX_W-1:0] offsT;

  // word 0 sits in the low bits
  typedef logic [`CACHE_WORDS-1:0][`XLEN-1:0] lineT;

  // field order matches the address bits
  typedef struct packed {
    tagT  tag;
    idxT  idx;
    offsT offs;
  } cacheReqT;

  // one way's view of the current lookup
  typedef struct packed {
    logic valid;
    logic hit;
    lineT line;
  } wayRespT;

  // line write, shared by both ways and the LRU
  typedef struct packed {
    logic we;
    logic way;
    idxT  idx;
    tagT  tag;
    lineT line;
  } refillT;

endpackage

`default_nettype wire

// ==== common/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// requester address width
`define ADDR_W 32

// data word width
`define XLEN 64

// sets per way
`define CACHE_SETS 64

// words per line
`define CACHE_WORDS 4

// address split, offset takes the remaining low bits
`define TAG_W 21
`define IDX_W 6

`endif
